//--- filelist.f
logic/corePkg.sv
logic/regFile.sv
logic/decodeStage.sv
logic/forwardUnit.sv
logic/aluCore.sv
logic/executeStage.sv
logic/resultStage.sv
logic/coreTop.sv
verif/coreChecker.sv
verif/coreTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module coreTb -f filelist.f -o coreSim

simOut="$(./obj_dir/coreSim)"
echo "$simOut"

if echo "$simOut" | grep -qxF "Done: no errors"; then
  exit 0
fi
exit 1

//--- verif/coreTb.sv
`timescale 1ns/1ps

module coreTb;
  import corePkg::*;

  localparam int nameLen = 12;

  typedef struct packed {
    logic                 valid;
    logic [3:0]           op;
    logic                 immFlag;
    logic [3:0]           rn;
    logic [3:0]           rd;
    logic [3:0]           rm;
    logic [4:0]           shAmt;
    logic [1:0]           shType;
    logic [7:0]           imm8;
    logic                 randImm;  // imm8 comes from the generator
    logic [8*nameLen-1:0] name;
  } rowT;

  logic                 clk;
  logic                 rstN;
  logic                 instrValid;
  logic [31:0]          instr;
  logic [8*nameLen-1:0] testName;
  logic                 wbValid;
  logic [3:0]           wbReg;
  logic [31:0]          wbData;
  int                   passCount;
  int                   failCount;
  int                   pendingCount;
  int                   cycleCount = 0;
  int                   cycleLimit = 0;  // Set once the table is built
  rowT                  rows [$];
  logic [31:0]          rngState;

  coreTop dut (
    .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  coreChecker scoreboard (
    .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr), .testName(testName),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData),
    .passCount(passCount), .failCount(failCount), .pendingCount(pendingCount)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Left aligned, space padded
  function automatic logic [8*nameLen-1:0] packName(input string s);
    logic [8*nameLen-1:0] p;
    p = {nameLen{8'h20}};
    for (int i = 0; i < s.len() && i < nameLen; i++) p[8*(nameLen-1-i) +: 8] = s[i];
    return p;
  endfunction

  function automatic logic [31:0] encode(input rowT r, input logic [7:0] imm8);
    logic [31:0] w;
    w = '0;
    w[25]    = r.immFlag;
    w[24:21] = r.op;
    w[19:16] = r.rn;
    w[15:12] = r.rd;
    if (r.immFlag) begin
      w[7:0] = imm8;
    end else begin
      w[11:7] = r.shAmt;
      w[6:5]  = r.shType;
      w[3:0]  = r.rm;
    end
    return w;
  endfunction

  task automatic addRow(input logic vld, input logic [3:0] op, input logic imm,
                        input logic [3:0] rn, rd, rm, input logic [4:0] amt,
                        input logic [1:0] sh, input logic [7:0] imm8, input logic rnd,
                        input string name);
    rows.push_back('{vld, op, imm, rn, rd, rm, amt, sh, imm8, rnd, packName(name)});
  endtask

  task automatic immRow(input logic [3:0] op, rn, rd, input logic [7:0] imm8, input string name);
    addRow(1'b1, op, 1'b1, rn, rd, 4'd0, 5'd0, 2'd0, imm8, 1'b0, name);
  endtask

  task automatic regRow(input logic [3:0] op, rn, rd, rm, input logic [4:0] amt,
                        input logic [1:0] sh, input string name);
    addRow(1'b1, op, 1'b0, rn, rd, rm, amt, sh, 8'd0, 1'b0, name);
  endtask

  task automatic randRow(input logic [3:0] op, rn, rd, input string name);
    addRow(1'b1, op, 1'b1, rn, rd, 4'd0, 5'd0, 2'd0, 8'd0, 1'b1, name);
  endtask

  // Strobe low, fields still look like mov r4
  task automatic gapRow(input string name);
    addRow(1'b0, opMov, 1'b1, 4'd0, 4'd4, 4'd0, 5'd0, 2'd0, 8'hee, 1'b0, name);
  endtask

  task automatic buildTable();
    immRow(opMov, 0, 1, 8'h05, "movImm");
    immRow(opMov, 0, 2, 8'hff, "movImm");
    immRow(opMov, 0, 3, 8'h80, "movImm");
    immRow(opAdd, 3, 4, 8'h01, "addImm");
    immRow(opMov, 0, 15, 8'h0f, "movR15");
    regRow(opAnd, 2, 5, 3, 0, shLsl, "andReg");
    regRow(opEor, 2, 6, 1, 0, shLsl, "eorReg");
    regRow(opSub, 1, 7, 2, 0, shLsl, "subWrap");   // 5 - 255
    regRow(opAdd, 7, 8, 7, 0, shLsl, "addWrap");   // Carry out dropped
    regRow(opOrr, 1, 9, 3, 0, shLsl, "orrReg");
    regRow(opMov, 0, 10, 15, 0, shLsl, "movReg");
    regRow(opBic, 2, 11, 1, 0, shLsl, "bicReg");
    randRow(opAnd, 8, 12, "andRnd");
    randRow(opEor, 8, 13, "eorRnd");
    randRow(opSub, 1, 14, "subRnd");
    randRow(opAdd, 7, 12, "addRnd");
    randRow(opOrr, 3, 13, "orrRnd");
    randRow(opMov, 0, 14, "movRnd");
    randRow(opBic, 8, 11, "bicRnd");
    regRow(opMov, 0, 12, 3, 24, shLsl, "lsl24");   // 0x80000000
    regRow(opMov, 0, 13, 12, 4, shAsr, "asr4");
    regRow(opMov, 0, 13, 12, 0, shAsr, "asr0");
    regRow(opMov, 0, 14, 12, 31, shLsr, "lsr31");
    regRow(opAdd, 1, 14, 8, 3, shLsr, "lsr3");
    regRow(opMov, 0, 11, 2, 4, shRor, "ror4");
    regRow(opMov, 0, 11, 2, 0, shRor, "ror0");
    regRow(opEor, 1, 11, 8, 7, shLsl, "lsl7");
    regRow(opSub, 2, 10, 7, 1, shAsr, "asr1");
    immRow(opMov, 0, 5, 8'h11, "fwdSetup");
    regRow(opAdd, 5, 5, 5, 0, shLsl, "fwdMBoth");  // Both operands from M
    immRow(opMov, 0, 6, 8'h22, "fwdSetup");
    immRow(opMov, 0, 7, 8'h33, "fwdSetup");
    regRow(opAdd, 7, 8, 6, 0, shLsl, "fwdMW");     // A from M, B from W
    immRow(opMov, 0, 10, 8'h44, "wrThrough");
    gapRow("gap");
    gapRow("gap");
    regRow(opAdd, 10, 9, 10, 1, shLsl, "dist3");   // Reads the write-through
    immRow(opMov, 0, 4, 8'h01, "sameDstW");
    immRow(opMov, 0, 4, 8'h02, "sameDstM");
    regRow(opOrr, 4, 3, 4, 0, shLsl, "mWins");
    regRow(4'd3, 4, 4, 4, 0, shLsl, "badOp");      // No such opcode
    regRow(opAdd, 4, 12, 4, 0, shLsl, "afterBad");
    gapRow("gapMov");
    regRow(4'd8, 0, 4, 1, 0, shLsl, "badOp8");
    regRow(opSub, 4, 13, 1, 0, shLsl, "afterGap");
  endtask

  task automatic applyRow(input rowT r);
    logic [7:0] imm8;
    imm8 = r.imm8;
    if (r.randImm) begin
      rngState = xorshift(rngState);
      imm8 = rngState[7:0];
    end
    @(negedge clk);
    instrValid = r.valid;
    instr      = encode(r, imm8);
    testName   = r.name;
  endtask

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Rows, reset, pipeline depth, margin
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    int missing;
    rstN       = 1'b0;
    instrValid = 1'b0;
    instr      = '0;
    testName   = '0;
    rngState   = 32'd55;
    buildTable();
    cycleLimit = rows.size() + 16 + 3 + 20;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    foreach (rows[i]) applyRow(rows[i]);
    @(negedge clk);
    instrValid = 1'b0;
    repeat (6) @(negedge clk);  // Latency is 3, extra cycles catch stray strobes
    missing = pendingCount;
    if (missing != 0) $display("Missing writebacks: %0d instructions never wrote back", missing);
    $display("Passed: %0d  failed: %0d  missing: %0d", passCount, failCount, missing);
    if (failCount == 0 && missing == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- verif/coreChecker.sv
`timescale 1ns/1ps

module coreChecker (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             instrValid,
  input  logic [corePkg::instrWidth-1:0]   instr,
  input  logic [95:0]                      testName,  // 12 ASCII chars
  input  logic                             wbValid,
  input  logic [corePkg::regAddrWidth-1:0] wbReg,
  input  logic [corePkg::dataWidth-1:0]    wbData,
  output int                               passCount,
  output int                               failCount,
  output int                               pendingCount
);
  import corePkg::*;

  logic [dataWidth-1:0]    model [numRegs];  // Register state after every issued instruction
  logic [regAddrWidth-1:0] expReg [$];
  logic [dataWidth-1:0]    expData [$];
  int                      expCycle [$];     // Issue cycle, for the latency check
  logic [95:0]             expName [$];
  int                      cycle;

  function automatic logic opKnown(input logic [3:0] op);
    return op inside {4'd0, 4'd1, 4'd2, 4'd4, 4'd12, 4'd13, 4'd14};
  endfunction

  // One bit position per step
  function automatic logic [31:0] shiftOperand(input logic [31:0] v, input logic [4:0] amt,
                                               input logic [1:0] kind);
    logic [31:0] r;
    r = v;
    for (int i = 0; i < 32; i++) begin
      if (i < int'(amt)) begin
        case (kind)
          2'd0:    r = {r[30:0], 1'b0};   // lsl
          2'd1:    r = {1'b0, r[31:1]};   // lsr
          2'd2:    r = {r[31], r[31:1]};  // asr keeps the sign
          default: r = {r[0], r[31:1]};   // ror
        endcase
      end
    end
    return r;
  endfunction

  function automatic logic [31:0] aluModel(input logic [3:0] op, input logic [31:0] a, b);
    case (op)
      4'd0:    return a & b;
      4'd1:    return a ^ b;
      4'd2:    return a - b;  // Wraps at 32 bits
      4'd4:    return a + b;
      4'd12:   return a | b;
      4'd13:   return b;
      default: return a & ~b;  // bic
    endcase
  endfunction

  always @(posedge clk) begin
    logic [dataWidth-1:0]    a;
    logic [dataWidth-1:0]    b;
    logic [3:0]              op;
    logic [regAddrWidth-1:0] eReg;
    logic [dataWidth-1:0]    eData;
    logic [95:0]             eName;
    int                      lat;
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) model[i] = '0;
      expReg.delete();
      expData.delete();
      expCycle.delete();
      expName.delete();
      cycle = 0;
      passCount = 0;
      failCount = 0;
    end else begin
      cycle++;
      if (wbValid) begin
        if (expReg.size() == 0) begin
          $display("ERROR @%0t: writeback with no instruction pending (r%0d = %08h)",
                   $time, wbReg, wbData);
          failCount++;
        end else begin
          eReg  = expReg.pop_front();
          eData = expData.pop_front();
          eName = expName.pop_front();
          lat   = cycle - expCycle.pop_front();
          if (wbReg !== eReg || wbData !== eData) begin
            $display("CHECK FAILED @%0t: %s got r%0d = %08h, expected r%0d = %08h",
                     $time, eName, wbReg, wbData, eReg, eData);
            failCount++;
          end else if (lat != 3) begin
            $display("CHECK FAILED @%0t: %s r%0d written %0d cycles after issue, expected 3",
                     $time, eName, eReg, lat);
            failCount++;
          end else begin
            $display("ok  %s r%0d = %08h", eName, eReg, eData);
            passCount++;
          end
        end
      end
      // Unknown opcodes never reach writeback
      op = instr[opcodeLsb +: opWidth];
      if (instrValid && opKnown(op)) begin
        a = model[instr[rnLsb +: regAddrWidth]];
        b = instr[immFlagBit] ? {24'd0, instr[imm8Lsb +: imm8Width]}
                              : shiftOperand(model[instr[rmLsb +: regAddrWidth]],
                                             instr[shAmtLsb +: shAmtWidth],
                                             instr[shTypeLsb +: shTypeWidth]);
        model[instr[rdLsb +: regAddrWidth]] = aluModel(op, a, b);
        expReg.push_back(instr[rdLsb +: regAddrWidth]);
        expData.push_back(model[instr[rdLsb +: regAddrWidth]]);
        expCycle.push_back(cycle);
        expName.push_back(testName);
      end
    end
    pendingCount = expReg.size();
  end

endmodule

//--- logic/coreTop.sv
`timescale 1ns/1ps

module coreTop (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             instrValid,
  input  logic [corePkg::instrWidth-1:0]   instr,
  output logic                             wbValid,
  output logic [corePkg::regAddrWidth-1:0] wbReg,
  output logic [corePkg::dataWidth-1:0]    wbData
);
  import corePkg::*;

  // Register file read side
  logic [regAddrWidth-1:0] raAddr;
  logic [regAddrWidth-1:0] rbAddr;
  logic [dataWidth-1:0]    raData;
  logic [dataWidth-1:0]    rbData;

  // E stage
  logic                    eValid;
  aluOpT                   eOp;
  logic                    eImmFlag;
  logic [dataWidth-1:0]    eImm;
  logic [shAmtWidth-1:0]   eShiftAmt;
  shiftT                   eShiftType;
  logic [regAddrWidth-1:0] eRa;
  logic [regAddrWidth-1:0] eRb;
  logic [dataWidth-1:0]    eRaData;
  logic [dataWidth-1:0]    eRbData;
  logic [regAddrWidth-1:0] eRd;

  // M stage
  logic                    exValid;
  logic [regAddrWidth-1:0] exRd;
  logic [dataWidth-1:0]    exResult;
  logic                    mValid;
  logic [regAddrWidth-1:0] mRd;
  logic [dataWidth-1:0]    mData;

  regFile regs (
    .clk(clk), .rstN(rstN),
    .raAddr(raAddr), .rbAddr(rbAddr), .raData(raData), .rbData(rbData),
    .we(wbValid), .wAddr(wbReg), .wData(wbData)    // Written from W
  );

  decodeStage decode (
    .clk(clk), .rstN(rstN), .instrValid(instrValid), .instr(instr),
    .raAddr(raAddr), .rbAddr(rbAddr), .raData(raData), .rbData(rbData),
    .eValid(eValid), .eOp(eOp), .eImmFlag(eImmFlag), .eImm(eImm),
    .eShiftAmt(eShiftAmt), .eShiftType(eShiftType), .eRa(eRa), .eRb(eRb),
    .eRaData(eRaData), .eRbData(eRbData), .eRd(eRd)
  );

  executeStage execute (
    .clk(clk), .rstN(rstN), .eValid(eValid), .eOp(eOp), .eImmFlag(eImmFlag),
    .eImm(eImm), .eShiftAmt(eShiftAmt), .eShiftType(eShiftType), .eRa(eRa),
    .eRb(eRb), .eRaData(eRaData), .eRbData(eRbData), .eRd(eRd),
    .mValid(mValid), .mRd(mRd), .mData(mData),
    .wValid(wbValid), .wRd(wbReg), .wData(wbData),   // W forward path
    .exValid(exValid), .exRd(exRd), .exResult(exResult)
  );

  resultStage result (
    .clk(clk), .rstN(rstN), .exValid(exValid), .exRd(exRd), .exResult(exResult),
    .mValid(mValid), .mRd(mRd), .mData(mData),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

endmodule

//--- logic/resultStage.sv
`timescale 1ns/1ps

module resultStage (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             exValid,
  input  logic [corePkg::regAddrWidth-1:0] exRd,
  input  logic [corePkg::dataWidth-1:0]    exResult,
  output logic                             mValid,
  output logic [corePkg::regAddrWidth-1:0] mRd,
  output logic [corePkg::dataWidth-1:0]    mData,
  output logic                             wbValid,
  output logic [corePkg::regAddrWidth-1:0] wbReg,
  output logic [corePkg::dataWidth-1:0]    wbData
);
  import corePkg::*;

  logic [regAddrWidth-1:0] wRdQ;
  logic [dataWidth-1:0]    wDataQ;

  // M stage, the register filled by execute, seen as forward source
  assign mValid = exValid;
  assign mRd    = exRd;
  assign mData  = exResult;

  // M to W strobe, high for one cycle per instruction
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbValid <= 1'b0;
    end else begin
      wbValid <= mValid;
    end
  end

  // Payload only moves with a valid result
  always_ff @(posedge clk) begin
    if (mValid) begin
      wRdQ   <= mRd;
      wDataQ <= mData;
    end
  end

  assign wbReg  = wRdQ;     // Also regfile write port and W forward
  assign wbData = wDataQ;

endmodule

//--- logic/executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             eValid,
  input  corePkg::aluOpT                   eOp,
  input  logic                             eImmFlag,
  input  logic [corePkg::dataWidth-1:0]    eImm,
  input  logic [corePkg::shAmtWidth-1:0]   eShiftAmt,
  input  corePkg::shiftT                   eShiftType,
  input  logic [corePkg::regAddrWidth-1:0] eRa,
  input  logic [corePkg::regAddrWidth-1:0] eRb,
  input  logic [corePkg::dataWidth-1:0]    eRaData,
  input  logic [corePkg::dataWidth-1:0]    eRbData,
  input  logic [corePkg::regAddrWidth-1:0] eRd,
  input  logic                             mValid,
  input  logic [corePkg::regAddrWidth-1:0] mRd,
  input  logic [corePkg::dataWidth-1:0]    mData,
  input  logic                             wValid,
  input  logic [corePkg::regAddrWidth-1:0] wRd,
  input  logic [corePkg::dataWidth-1:0]    wData,
  output logic                             exValid,
  output logic [corePkg::regAddrWidth-1:0] exRd,
  output logic [corePkg::dataWidth-1:0]    exResult
);
  import corePkg::*;

  fwdSelT               fwdA;
  fwdSelT               fwdB;
  logic [dataWidth-1:0] srcA;
  logic [dataWidth-1:0] srcB;      // Before shift and imm select
  logic [dataWidth-1:0] aluResult;

  // Bypass mux, one per operand
  function automatic logic [dataWidth-1:0] fwdMux(
    input fwdSelT               sel,
    input logic [dataWidth-1:0] regVal,
    input logic [dataWidth-1:0] mVal,
    input logic [dataWidth-1:0] wVal
  );
    logic [dataWidth-1:0] val;
    case (sel)
      fwdM:    val = mVal;
      fwdW:    val = wVal;
      default: val = regVal;
    endcase
    return val;
  endfunction

  forwardUnit fwdUnit (
    .eRa    (eRa),
    .eRb    (eRb),
    .mValid (mValid),
    .mRd    (mRd),
    .wValid (wValid),
    .wRd    (wRd),
    .fwdA   (fwdA),
    .fwdB   (fwdB)
  );

  assign srcA = fwdMux(fwdA, eRaData, mData, wData);
  assign srcB = fwdMux(fwdB, eRbData, mData, wData);

  aluCore alu (
    .op        (eOp),
    .a         (srcA),
    .rbVal     (srcB),
    .immFlag   (eImmFlag),   // Operand B select lives in the ALU
    .imm       (eImm),
    .shiftAmt  (eShiftAmt),
    .shiftType (eShiftType),
    .result    (aluResult)
  );

  // E to M
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      exValid <= 1'b0;
    end else begin
      exValid <= eValid;
    end
  end

  always_ff @(posedge clk) begin
    exRd     <= eRd;
    exResult <= aluResult;
  end

endmodule

//--- logic/aluCore.sv
`timescale 1ns/1ps

module aluCore (
  input  corePkg::aluOpT                 op,
  input  logic [corePkg::dataWidth-1:0]  a,
  input  logic [corePkg::dataWidth-1:0]  rbVal,
  input  logic                           immFlag,
  input  logic [corePkg::dataWidth-1:0]  imm,
  input  logic [corePkg::shAmtWidth-1:0] shiftAmt,
  input  corePkg::shiftT                 shiftType,
  output logic [corePkg::dataWidth-1:0]  result
);
  import corePkg::*;

  logic [dataWidth-1:0]   shifted;
  logic [2*dataWidth-1:0] rotWide;  // Doubled word for rotate
  logic [dataWidth-1:0]   b;

  assign rotWide = {rbVal, rbVal} >> shiftAmt;

  // Immediate shifter on the second register, amount 0 passes through
  always_comb begin
    case (shiftType)
      shLsl:   shifted = rbVal << shiftAmt;
      shLsr:   shifted = rbVal >> shiftAmt;
      shAsr:   shifted = $signed(rbVal) >>> shiftAmt;  // Sign fill
      shRor:   shifted = rotWide[dataWidth-1:0];
      default: shifted = rbVal;
    endcase
  end

  // Operand B, imm skips the shifter
  assign b = immFlag ? imm : shifted;

  // Data-processing ops, arithmetic wraps at 32 bits
  always_comb begin
    case (op)
      opAnd:   result = a & b;
      opEor:   result = a ^ b;
      opSub:   result = a - b;
      opAdd:   result = a + b;
      opOrr:   result = a | b;
      opMov:   result = b;       // A ignored
      opBic:   result = a & ~b;
      default: result = '0;
    endcase
  end

endmodule

//--- logic/forwardUnit.sv
`timescale 1ns/1ps

module forwardUnit (
  input  logic [corePkg::regAddrWidth-1:0] eRa,
  input  logic [corePkg::regAddrWidth-1:0] eRb,
  input  logic                             mValid,
  input  logic [corePkg::regAddrWidth-1:0] mRd,
  input  logic                             wValid,
  input  logic [corePkg::regAddrWidth-1:0] wRd,
  output corePkg::fwdSelT                  fwdA,
  output corePkg::fwdSelT                  fwdB
);
  import corePkg::*;

  // M is younger than W so it is checked first
  function automatic fwdSelT pickSrc(
    input logic [regAddrWidth-1:0] src,
    input logic                    mVld,
    input logic [regAddrWidth-1:0] mDst,
    input logic                    wVld,
    input logic [regAddrWidth-1:0] wDst
  );
    fwdSelT sel;
    if (mVld && (mDst == src)) begin
      sel = fwdM;
    end else if (wVld && (wDst == src)) begin
      sel = fwdW;
    end else begin
      sel = fwdReg;  // Decode read already current
    end
    return sel;
  endfunction

  assign fwdA = pickSrc(eRa, mValid, mRd, wValid, wRd);
  assign fwdB = pickSrc(eRb, mValid, mRd, wValid, wRd);  // Shifter input, not imm

endmodule

//--- logic/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic                             instrValid,
  input  logic [corePkg::instrWidth-1:0]   instr,
  output logic [corePkg::regAddrWidth-1:0] raAddr,
  output logic [corePkg::regAddrWidth-1:0] rbAddr,
  input  logic [corePkg::dataWidth-1:0]    raData,
  input  logic [corePkg::dataWidth-1:0]    rbData,
  output logic                             eValid,
  output corePkg::aluOpT                   eOp,
  output logic                             eImmFlag,
  output logic [corePkg::dataWidth-1:0]    eImm,
  output logic [corePkg::shAmtWidth-1:0]   eShiftAmt,
  output corePkg::shiftT                   eShiftType,
  output logic [corePkg::regAddrWidth-1:0] eRa,
  output logic [corePkg::regAddrWidth-1:0] eRb,
  output logic [corePkg::dataWidth-1:0]    eRaData,
  output logic [corePkg::dataWidth-1:0]    eRbData,
  output logic [corePkg::regAddrWidth-1:0] eRd
);
  import corePkg::*;

  aluOpT                 op;
  shiftT                 shType;
  logic                  opOk;     // Opcode is one we execute
  logic [dataWidth-1:0]  immExt;

  // Field split
  assign raAddr = instr[rnLsb +: regAddrWidth];
  assign rbAddr = instr[rmLsb +: regAddrWidth];
  assign op     = aluOpT'(instr[opcodeLsb +: opWidth]);
  assign shType = shiftT'(instr[shTypeLsb +: shTypeWidth]);

  // Zero extended, no rotation
  assign immExt = {{(dataWidth - imm8Width){1'b0}}, instr[imm8Lsb +: imm8Width]};

  always_comb begin
    case (op)
      opAnd, opEor, opSub, opAdd, opOrr, opMov, opBic: opOk = 1'b1;
      default: opOk = 1'b0;  // Unknown opcode becomes a bubble
    endcase
  end

  // D to E valid
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      eValid <= 1'b0;
    end else begin
      eValid <= instrValid && opOk;
    end
  end

  // D to E payload, loaded every cycle
  always_ff @(posedge clk) begin
    eOp        <= op;
    eImmFlag   <= instr[immFlagBit];
    eImm       <= immExt;
    eShiftAmt  <= instr[shAmtLsb +: shAmtWidth];
    eShiftType <= shType;
    eRa        <= raAddr;      // Kept for forwarding compares
    eRb        <= rbAddr;
    eRaData    <= raData;
    eRbData    <= rbData;
    eRd        <= instr[rdLsb +: regAddrWidth];
  end

endmodule

//--- logic/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic                             clk,
  input  logic                             rstN,
  input  logic [corePkg::regAddrWidth-1:0] raAddr,
  input  logic [corePkg::regAddrWidth-1:0] rbAddr,
  output logic [corePkg::dataWidth-1:0]    raData,
  output logic [corePkg::dataWidth-1:0]    rbData,
  input  logic                             we,
  input  logic [corePkg::regAddrWidth-1:0] wAddr,
  input  logic [corePkg::dataWidth-1:0]    wData
);
  import corePkg::*;

  logic [dataWidth-1:0] regs [numRegs];  // r15 is a plain register here
  logic                 hitA;
  logic                 hitB;

  // All registers start at zero
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[wAddr] <= wData;
    end
  end

  // Same-cycle write shows up on the read ports
  assign hitA = we && (raAddr == wAddr);
  assign hitB = we && (rbAddr == wAddr);

  assign raData = hitA ? wData : regs[raAddr];  // Bypass on write hit
  assign rbData = hitB ? wData : regs[rbAddr];

endmodule

//--- logic/corePkg.sv
package corePkg;

  // Datapath sizes
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 4;   // r0..r15
  localparam int numRegs      = 16;
  localparam int instrWidth   = 32;

  // Instruction field low bits, data-processing layout
  localparam int immFlagBit = 25;    // I bit, selects imm8 for operand B
  localparam int opcodeLsb  = 21;    // Bits 24:21
  localparam int rnLsb      = 16;    // Bits 19:16, first source
  localparam int rdLsb      = 12;    // Bits 15:12, destination
  localparam int shAmtLsb   = 7;     // Bits 11:7
  localparam int shTypeLsb  = 5;     // Bits 6:5
  localparam int rmLsb      = 0;     // Bits 3:0, second source
  localparam int imm8Lsb    = 0;     // Bits 7:0, overlaps shift and rm

  // Field widths
  localparam int opWidth     = 4;
  localparam int shAmtWidth  = 5;
  localparam int shTypeWidth = 2;
  localparam int imm8Width   = 8;

  // ARM data-processing opcodes kept by this core
  typedef enum logic [opWidth-1:0] {
    opAnd = 4'd0,
    opEor = 4'd1,
    opSub = 4'd2,
    opAdd = 4'd4,
    opOrr = 4'd12,
    opMov = 4'd13,
    opBic = 4'd14
  } aluOpT;

  typedef enum logic [shTypeWidth-1:0] {
    shLsl = 2'd0,
    shLsr = 2'd1,
    shAsr = 2'd2,
    shRor = 2'd3
  } shiftT;

  // Operand source in E, encoded like a 3-input mux select
  typedef enum logic [1:0] {
    fwdReg = 2'd0,  // Value read in decode
    fwdW   = 2'd1,  // Writeback stage
    fwdM   = 2'd2   // Memory stage, youngest result
  } fwdSelT;

endpackage
